//--- disp_pkg.sv
package disp_pkg;

  parameter int DATA_W = 32;
  parameter int ADDR_W = 4;
  parameter int NUM_DIGITS = 8;

  typedef enum logic [ADDR_W-1:0] {
    REG_VALUE = 4'h0,
    REG_CTRL  = 4'h4
  } reg_addr_e;

  // Active low, one digit at a time
  typedef enum logic [NUM_DIGITS-1:0] {
    A0     = 8'b11111110,
    A1     = 8'b11111101,
    A2     = 8'b11111011,
    A3     = 8'b11110111,
    A4     = 8'b11101111,
    A5     = 8'b11011111,
    A6     = 8'b10111111,
    A7     = 8'b01111111,
    AN_OFF = 8'b11111111
  } anode_e;

  // Segments a..g, msb first, active low
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
    logic [6:0] pat;
    case (nib)
      4'h0: pat = 7'b0000001;
      4'h1: pat = 7'b1001111;
      4'h2: pat = 7'b0010010;
      4'h3: pat = 7'b0000110;
      4'h4: pat = 7'b1001100;
      4'h5: pat = 7'b0100100;
      4'h6: pat = 7'b0100000;
      4'h7: pat = 7'b0001111;
      4'h8: pat = 7'b0000000;
      4'h9: pat = 7'b0000100;
      4'ha: pat = 7'b0001000;
      4'hb: pat = 7'b1100000;
      4'hc: pat = 7'b0110001;
      4'hd: pat = 7'b1000010;
      4'he: pat = 7'b0110000;
      default: pat = 7'b0111000;
    endcase
    return pat;
  endfunction

endpackage

//--- disp_if.sv
`timescale 1ns/1ns

interface digit_if
  import disp_pkg::*;
();

  logic [3:0] nibble;
  anode_e     anode;
  // Mask bit of this digit, or display disabled
  logic       blank;
  logic       valid;

  modport src(
    output nibble,
    output anode,
    output blank,
    output valid
  );

  modport dst(
    input nibble,
    input anode,
    input blank,
    input valid
  );

endinterface

//--- disp_regs.sv
`timescale 1ns/1ns

module disp_regs
  import disp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ADDR_W-1:0]     paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [DATA_W-1:0]     pwdata,
  output logic [DATA_W-1:0]     prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic [DATA_W-1:0]     value,
  output logic                  enable,
  output logic [NUM_DIGITS-1:0] blank_mask
);

  reg_addr_e         addr;
  logic              access;
  logic              mapped;
  logic [DATA_W-1:0] ctrl_word;

  assign addr   = reg_addr_e'(paddr);
  assign access = psel && penable;

  always_comb begin
    case (addr)
      REG_VALUE: mapped = 1'b1;
      REG_CTRL:  mapped = 1'b1;
      default:   mapped = 1'b0;
    endcase
  end

  // Reserved bits always read as zero
  always_comb begin
    ctrl_word = '0;
    ctrl_word[0] = enable;
    ctrl_word[15:8] = blank_mask;
  end

  // Zero wait states
  assign pready  = access;
  assign pslverr = access && !mapped;

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (addr)
        REG_VALUE: prdata = value;
        REG_CTRL:  prdata = ctrl_word;
        default:   prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value      <= '0;
      enable     <= 1'b0;
      blank_mask <= '0;
    end else if (access && pwrite) begin
      case (addr)
        REG_VALUE: value <= pwdata;
        REG_CTRL: begin
          enable     <= pwdata[0];
          blank_mask <= pwdata[15:8];
        end
        default: ;
      endcase
    end
  end

endmodule

//--- digit_scan.sv
`timescale 1ns/1ns

module digit_scan
  import disp_pkg::*;
#(
  parameter int SCAN_DIV = 1000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_W-1:0]     value,
  input  logic                  enable,
  input  logic [NUM_DIGITS-1:0] blank_mask,
  digit_if.src                  dig
);

  localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [CNT_W-1:0]      cnt;
  logic                  tick;
  anode_e                state;
  anode_e                state_nxt;
  logic                  frame_start;
  logic [DATA_W-1:0]     snap_value;
  logic [NUM_DIGITS-1:0] snap_mask;
  logic [DATA_W-1:0]     value_sel;
  logic [NUM_DIGITS-1:0] mask_sel;
  logic [3:0]            nibble_sel;
  logic                  blank_sel;

  assign tick = enable && (cnt == CNT_W'(SCAN_DIV - 1));

  always_ff @(posedge clk) begin
    if (!rst_n || !enable || tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign frame_start = tick && (state == AN_OFF || state == A7);

  always_comb begin
    state_nxt = state;
    if (!enable) begin
      state_nxt = AN_OFF;
    end else if (frame_start) begin
      state_nxt = A0;
    end else if (tick) begin
      // Rotate the low bit one digit up
      state_nxt = anode_e'({state[NUM_DIGITS-2:0], 1'b1});
    end
  end

  // Entering A0 uses the fresh copy, later digits the held one
  assign value_sel = frame_start ? value : snap_value;
  assign mask_sel  = frame_start ? blank_mask : snap_mask;

  always_comb begin
    nibble_sel = '0;
    blank_sel  = 1'b1;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      if (!state_nxt[i]) begin
        nibble_sel = value_sel[4*i +: 4];
        blank_sel  = mask_sel[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= AN_OFF;
      dig.anode <= AN_OFF;
      dig.valid <= 1'b0;
      dig.blank <= 1'b1;
    end else begin
      state     <= state_nxt;
      dig.anode <= state_nxt;
      dig.valid <= (state_nxt != AN_OFF);
      dig.blank <= blank_sel || !enable;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      snap_value <= value;
      snap_mask  <= blank_mask;
    end
    dig.nibble <= nibble_sel;
  end

endmodule

//--- seg_encode.sv
`timescale 1ns/1ns

module seg_encode
  import disp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  digit_if.dst                  dig,
  output logic [NUM_DIGITS-1:0] an,
  output logic [6:0]            seg
);

  logic [6:0] seg_nxt;

  // Dark unless a live, unblanked digit
  always_comb begin
    if (dig.blank || !dig.valid) begin
      seg_nxt = '1;
    end else begin
      seg_nxt = hex_to_seg(dig.nibble);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      an  <= AN_OFF;
      seg <= '1;
    end else begin
      an  <= dig.anode;
      seg <= seg_nxt;
    end
  end

endmodule

//--- disp_top.sv
`timescale 1ns/1ns

module disp_top
  import disp_pkg::*;
#(
  parameter int SCAN_DIV = 1000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ADDR_W-1:0]     paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [DATA_W-1:0]     pwdata,
  output logic [DATA_W-1:0]     prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic [NUM_DIGITS-1:0] an,
  output logic [6:0]            seg
);

  logic [DATA_W-1:0]     value;
  logic                  enable;
  logic [NUM_DIGITS-1:0] blank_mask;

  digit_if dig ();

  disp_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .value      (value),
    .enable     (enable),
    .blank_mask (blank_mask)
  );

  digit_scan #(
    .SCAN_DIV (SCAN_DIV)
  ) u_scan (
    .clk        (clk),
    .rst_n      (rst_n),
    .value      (value),
    .enable     (enable),
    .blank_mask (blank_mask),
    .dig        (dig.src)
  );

  seg_encode u_enc (
    .clk   (clk),
    .rst_n (rst_n),
    .dig   (dig.dst),
    .an    (an),
    .seg   (seg)
  );

endmodule

//--- disp_checker.sv
`timescale 1ns/1ns

module disp_checker
  import disp_pkg::*;
#(
  parameter int SCAN_DIV = 4
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic [ADDR_W-1:0]     paddr,
  input logic                  psel,
  input logic                  penable,
  input logic                  pwrite,
  input logic [DATA_W-1:0]     pwdata,
  input logic [DATA_W-1:0]     prdata,
  input logic                  pready,
  input logic                  pslverr,
  input logic [NUM_DIGITS-1:0] an,
  input logic [6:0]            seg,
  input logic                  exp_check,
  input logic [DATA_W-1:0]     exp_data,
  input logic                  exp_err
);

  // One frame plus pipeline slack
  localparam int WINDOW = NUM_DIGITS * SCAN_DIV + 8;

  int                    error_count = 0;
  int                    apb_errors = 0;
  int                    disp_errors = 0;
  int                    frames_checked = 0;
  int                    frames_skipped = 0;
  int unsigned           cycle = 0;
  int unsigned           ctrl_cycle = 0;
  int unsigned           frame_start = 0;
  int                    frame_next = -1;
  int                    d;
  logic [DATA_W-1:0]     m_value;
  logic                  m_enable;
  logic [NUM_DIGITS-1:0] m_mask;
  logic                  mapped;
  logic [DATA_W-1:0]     expect_rd;
  logic [NUM_DIGITS-1:0] exp_an;
  logic [NUM_DIGITS-1:0] prev_an = 8'hff;
  logic [6:0]            frame_seg [NUM_DIGITS];
  logic [DATA_W-1:0]     hist_val [$];
  int unsigned           hist_cyc [$];

  // Reference board table, a..g msb first, active low
  function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h01;
      4'h1: return 7'h4f;
      4'h2: return 7'h12;
      4'h3: return 7'h06;
      4'h4: return 7'h4c;
      4'h5: return 7'h24;
      4'h6: return 7'h20;
      4'h7: return 7'h0f;
      4'h8: return 7'h00;
      4'h9: return 7'h04;
      4'ha: return 7'h08;
      4'hb: return 7'h60;
      4'hc: return 7'h31;
      4'hd: return 7'h42;
      4'he: return 7'h30;
      default: return 7'h38;
    endcase
  endfunction

  function automatic logic is_anode(input logic [NUM_DIGITS-1:0] a);
    return (a == 8'hff) || $onehot(~a);
  endfunction

  function automatic int digit_of(input logic [NUM_DIGITS-1:0] a);
    int idx;
    idx = -1;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      if (!a[i]) idx = i;
    end
    return idx;
  endfunction

  function automatic logic frame_match(input logic [DATA_W-1:0] v);
    logic ok;
    logic [6:0] want;
    ok = 1'b1;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      want = m_mask[i] ? 7'h7f : seg_pattern(v[4*i +: 4]);
      if (frame_seg[i] != want) ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic check_frame();
    logic matched;
    matched = 1'b0;
    if (cycle - ctrl_cycle < WINDOW) begin
      frames_skipped++;
    end else begin
      // Newest first, down to the last value settled before the frame
      for (int k = hist_val.size() - 1; k >= 0; k--) begin
        if (frame_match(hist_val[k])) matched = 1'b1;
        if (hist_cyc[k] + WINDOW < frame_start) break;
      end
      if (matched) begin
        frames_checked++;
      end else begin
        disp_errors++;
        $display("Frame starting at cycle %0d matches no written value (model 0x%h)",
                 frame_start, m_value);
      end
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!rst_n) begin
      m_value    <= '0;
      m_enable   <= 1'b0;
      m_mask     <= '0;
      ctrl_cycle <= 0;
      hist_val.delete();
      hist_cyc.delete();
      hist_val.push_back('0);
      hist_cyc.push_back(0);
    end else if (psel && penable) begin
      mapped = (paddr == 4'h0) || (paddr == 4'h4);
      if (!pready) begin
        apb_errors++;
        $display("pready was low in an access cycle at cycle %0d", cycle);
      end
      if (pslverr !== !mapped) begin
        apb_errors++;
        $display("Mismatch pslverr: got 0x%h expected 0x%h", pslverr, !mapped);
      end
      if (pwrite) begin
        if (paddr == 4'h0) begin
          m_value <= pwdata;
          hist_val.push_back(pwdata);
          hist_cyc.push_back(cycle);
        end else if (paddr == 4'h4) begin
          m_enable   <= pwdata[0];
          m_mask     <= pwdata[15:8];
          ctrl_cycle <= cycle;
        end
      end else begin
        expect_rd = '0;
        if (paddr == 4'h0) expect_rd = m_value;
        if (paddr == 4'h4) expect_rd = {16'h0, m_mask, 7'h0, m_enable};
        if (prdata !== expect_rd) begin
          apb_errors++;
          $display("Mismatch prdata: got 0x%h expected 0x%h", prdata, expect_rd);
        end
        if (exp_check && prdata !== exp_data) begin
          apb_errors++;
          $display("Mismatch prdata: got 0x%h stim expects 0x%h", prdata, exp_data);
        end
        if (exp_check && pslverr !== exp_err) begin
          apb_errors++;
          $display("Mismatch pslverr: got 0x%h stim expects 0x%h", pslverr, exp_err);
        end
      end
    end else begin
      // Outside access cycles the slave stays quiet
      if (pready !== 1'b0 || pslverr !== 1'b0 || prdata !== '0) begin
        apb_errors++;
        $display("Mismatch idle pready/pslverr/prdata: got 0x%h/0x%h/0x%h expected 0",
                 pready, pslverr, prdata);
      end
    end
  end

  // an and seg settle after the rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      prev_an = 8'hff;
      frame_next = -1;
    end else begin
      if (!m_enable && cycle > ctrl_cycle + 4 && (an != 8'hff || seg != 7'h7f)) begin
        disp_errors++;
        $display("Mismatch an/seg while disabled: got 0x%h/0x%h expected 0xff/0x7f",
                 an, seg);
      end
      if (an !== prev_an) begin
        if (!is_anode(an)) begin
          disp_errors++;
          $display("Mismatch an: got 0x%h which is no anode pattern", an);
          frame_next = -1;
        end else if (an == 8'hff) begin
          if (seg != 7'h7f) begin
            disp_errors++;
            $display("Mismatch seg: got 0x%h expected 0x7f", seg);
          end
          frame_next = -1;
        end else begin
          d = digit_of(an);
          if (prev_an == 8'hff && d != 0) begin
            disp_errors++;
            $display("Mismatch an: got 0x%h expected 0xfe after a dark display", an);
          end else if (is_anode(prev_an) && prev_an != 8'hff) begin
            exp_an = ~(8'h01 << ((digit_of(prev_an) + 1) % NUM_DIGITS));
            if (an != exp_an) begin
              disp_errors++;
              $display("Mismatch an: got 0x%h expected 0x%h", an, exp_an);
            end
          end
          if (d == 0) begin
            frame_next = 0;
            frame_start = cycle;
          end
          if (frame_next == d) begin
            frame_seg[d] = seg;
            frame_next = d + 1;
            if (d == NUM_DIGITS - 1) check_frame();
          end else begin
            frame_next = -1;
          end
        end
        prev_an = an;
      end
    end
  end

  task automatic print_summary(input int stim_errors);
    error_count = apb_errors + disp_errors + stim_errors;
    if (frames_checked == 0) begin
      error_count++;
      $display("No complete display frame was checked");
    end
    $display("Checker done: %0d errors, %0d frames checked, %0d frames skipped",
             error_count, frames_checked, frames_skipped);
  endtask

endmodule

//--- disp_assert.sv
`timescale 1ns/1ns

module disp_assert
  import disp_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  psel,
  input logic                  penable,
  input logic                  pready,
  input logic                  enable,
  input logic [NUM_DIGITS-1:0] an
);

  pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pready == (psel && penable))
    else $error("pready differs from the access cycle");

  an_pattern: assert property (@(posedge clk) disable iff (!rst_n)
    (an == 8'hff) || $onehot(~an))
    else $error("an is neither one active digit nor all off");

  // Two cycles of pipeline from enable to an
  an_off_when_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(!enable) && $past(!enable, 2)) |-> (an == 8'hff))
    else $error("an still driven after enable went low");

endmodule

bind disp_top disp_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .enable  (enable),
  .an      (an)
);

//--- tb_disp.sv
`timescale 1ns/1ns

module tb_disp
  import disp_pkg::*;
();

  localparam int SCAN_DIV = 4;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_LINES = 64;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [ADDR_W-1:0]     paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [DATA_W-1:0]     pwdata;
  logic [DATA_W-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;
  logic [NUM_DIGITS-1:0] an;
  logic [6:0]            seg;
  logic                  exp_check;
  logic [DATA_W-1:0]     exp_data;
  logic                  exp_err;

  logic [3:0]        op_q [MAX_LINES];
  logic [ADDR_W-1:0] addr_q [MAX_LINES];
  logic [DATA_W-1:0] data_q [MAX_LINES];
  logic [DATA_W-1:0] expd_q [MAX_LINES];
  logic              experr_q [MAX_LINES];
  int                num_lines = 0;
  int                stim_errors = 0;
  int                cycles = 0;
  int                limit = 0;
  logic              limit_ready = 1'b0;
  logic [DATA_W-1:0] last_rand = '0;

  always #4 clk = ~clk;

  disp_top #(
    .SCAN_DIV (SCAN_DIV)
  ) UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .an      (an),
    .seg     (seg)
  );

  disp_checker #(
    .SCAN_DIV (SCAN_DIV)
  ) chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .an        (an),
    .seg       (seg),
    .exp_check (exp_check),
    .exp_data  (exp_data),
    .exp_err   (exp_err)
  );

  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    fd = $fopen("disp_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open disp_stim.txt");
      stim_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, data_q[num_lines],
                    expd_q[num_lines], experr_q[num_lines]);
        if (line.len() > 0 && line[0] != "#" && n == 5 && num_lines < MAX_LINES) begin
          op_q[num_lines] = f_op[3:0];
          addr_q[num_lines] = f_addr[ADDR_W-1:0];
          num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel      = 1'b0;
    penable   = 1'b0;
    exp_check = 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] want,
                          input logic want_err);
    exp_data  = want;
    exp_err   = want_err;
    exp_check = 1'b1;
    apb_xfer(1'b0, addr, '0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit_ready && cycles >= limit) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    exp_check = 1'b0;
    exp_data  = '0;
    exp_err   = 1'b0;
    void'($urandom(51366));
    load_stim();
    for (int i = 0; i < num_lines; i++) begin
      limit += (op_q[i] == 4'h3 ? int'(data_q[i]) : 1) * (2 * NUM_DIGITS * SCAN_DIV + 10);
    end
    limit += RESET_CYCLES + 16;
    limit_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < num_lines; i++) begin
      case (op_q[i])
        4'h1: apb_xfer(1'b1, addr_q[i], data_q[i]);
        4'h2: apb_read(addr_q[i], expd_q[i], experr_q[i]);
        4'h3: repeat (int'(data_q[i]) * NUM_DIGITS * SCAN_DIV) @(negedge clk);
        4'h4: begin
          last_rand = $urandom;
          apb_xfer(1'b1, addr_q[i], last_rand);
        end
        4'h5: apb_read(addr_q[i], last_rand, 1'b0);
        default: begin
          $display("Unknown stim operation %0h on entry %0d", op_q[i], i);
          stim_errors++;
        end
      endcase
    end
    repeat (4) @(negedge clk);
    chk.print_summary(stim_errors);
    if (chk.error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- disp_stim.txt
# op addr data exp_data exp_err, all hex
# op 1 write, 2 read, 3 wait data frames, 4 write random, 5 read last random
1 0 89abcdef 0 0
2 0 0 89abcdef 0
1 4 ffffa501 0 0
2 4 0 0000a501 0
3 0 3 0 0
1 4 00000001 0 0
2 4 0 00000001 0
3 0 3 0 0
1 8 12345678 0 0
2 8 0 0 1
2 0 0 89abcdef 0
2 4 0 00000001 0
1 4 00000000 0 0
3 0 2 0 0
1 4 00000001 0 0
3 0 3 0 0
4 0 0 0 0
4 0 0 0 0
4 0 0 0 0
4 0 0 0 0
4 0 0 0 0
4 0 0 0 0
5 0 0 0 0
3 0 3 0 0
1 c deadbeef 0 0
2 c 0 0 1
1 0 01234567 0 0
3 0 3 0 0

//--- list.f
disp_pkg.sv
disp_if.sv
disp_regs.sv
digit_scan.sv
seg_encode.sv
disp_top.sv
disp_checker.sv
disp_assert.sv
tb_disp.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_disp
RTL_TOP   ?= disp_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= disp_pkg.sv disp_if.sv disp_regs.sv digit_scan.sv seg_encode.sv disp_top.sv
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
